//--- rtl/hbic_cfg.svh
`ifndef HBIC_CFG_SVH
`define HBIC_CFG_SVH

// masters sharing the memory port
`define HBIC_PORTS   4

// memory-side channel widths
`define HBIC_ADDR_W  32
`define HBIC_DATA_W  128 // 16-byte beats, INCR only
`define HBIC_STRB_W  16
`define HBIC_ID_W    4
`define HBIC_LEN_W   8   // beats minus one

`endif

//--- rtl/hbic_bus_pkg.sv
`default_nettype none

`include "hbic_cfg.svh"

package hbic_bus_pkg;

	typedef logic [`HBIC_ADDR_W-1:0] addr_t;
	typedef logic [`HBIC_DATA_W-1:0] data_t;
	typedef logic [`HBIC_STRB_W-1:0] strb_t;
	typedef logic [`HBIC_ID_W-1:0]   id_t;
	typedef logic [`HBIC_LEN_W-1:0]  len_t;

	// address request as issued by one master
	typedef struct packed {
		addr_t addr;
		len_t  len;
	} addr_req_t;

	// combined request toward the memory controller
	typedef struct packed {
		id_t   id;    // issuing master index
		addr_t addr;
		len_t  len;
		logic  write; // 1 write, 0 read
	} arw_req_t;

	// write data beat, no id since one writer owns the channel at a time
	typedef struct packed {
		data_t data;
		strb_t strb;
		logic  last;
	} w_beat_t;

	// read data beat, id steers it back to its master
	typedef struct packed {
		id_t   id;
		data_t data;
		logic  last;
	} r_beat_t;

endpackage

`default_nettype wire

//--- rtl/hbic_port_pkg.sv
`default_nettype none

`include "hbic_cfg.svh"

package hbic_port_pkg;

	// master index, also the request id on the memory side
	typedef logic [$clog2(`HBIC_PORTS)-1:0] port_idx_t;

	// arbitration source is {master, read bit}, so writes sit on even indices
	typedef logic [$clog2(`HBIC_PORTS):0] src_idx_t;

	typedef logic [2*`HBIC_PORTS-1:0] src_mask_t; // one bit per source

	typedef enum logic [0:0] {
		IDLE  = 1'b0, // free to take a grant
		WDATA = 1'b1  // write data owned by one master
	} merge_state_e;

endpackage

`default_nettype wire

//--- rtl/request_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

`include "hbic_cfg.svh"

module request_arbiter (
	input  wire                             sys_clk_i,
	input  wire                             rst_i,
	input  wire        [`HBIC_PORTS-1:0]    aw_valid_i,
	input  wire        [`HBIC_PORTS-1:0]    ar_valid_i,
	input  wire                             grant_ready_i,
	output hbic_port_pkg::src_idx_t         grant_o,
	output logic                            grant_valid_o,
	output logic       [`HBIC_PORTS-1:0]    aw_ready_o,
	output logic       [`HBIC_PORTS-1:0]    ar_ready_o
);

	hbic_port_pkg::src_mask_t req;   // all pending sources
	hbic_port_pkg::src_idx_t  ptr_q; // highest priority source
	hbic_port_pkg::src_idx_t  cand;
	logic                     grant_hs;

	// interleave so source 2p is the write and 2p+1 the read of master p
	always_comb begin
		for (int p = 0; p < `HBIC_PORTS; p++) begin
			req[2*p]   = aw_valid_i[p];
			req[2*p+1] = ar_valid_i[p];
		end
	end

	// walk down from the far end so the source nearest the pointer wins
	always_comb begin
		grant_o       = ptr_q;
		grant_valid_o = 1'b0;
		cand          = ptr_q;
		for (int i = 2*`HBIC_PORTS-1; i >= 0; i--) begin
			cand = ptr_q + hbic_port_pkg::src_idx_t'(i); // wraps at 8
			if (req[cand]) begin
				grant_o       = cand;
				grant_valid_o = 1'b1;
			end
		end
	end

	assign grant_hs = grant_valid_o & grant_ready_i;

	// ready only toward the winner, in the cycle the merger takes it
	always_comb begin
		for (int p = 0; p < `HBIC_PORTS; p++) begin
			aw_ready_o[p] = grant_hs && (grant_o == {hbic_port_pkg::port_idx_t'(p), 1'b0});
			ar_ready_o[p] = grant_hs && (grant_o == {hbic_port_pkg::port_idx_t'(p), 1'b1});
		end
	end

	always_ff @(posedge sys_clk_i) begin
		if (rst_i) begin
			ptr_q <= '0;
		end else if (grant_hs) begin
			ptr_q <= grant_o + 1'b1; // source after the winner
		end
	end

endmodule

`default_nettype wire

//--- rtl/arw_merger.sv
`timescale 1ns/10ps
`default_nettype none

`include "hbic_cfg.svh"

module arw_merger (
	input  wire                                               sys_clk_i,
	input  wire                                               rst_i,
	input  wire hbic_port_pkg::src_idx_t                      grant_i,
	input  wire                                               grant_valid_i,
	input  wire hbic_bus_pkg::addr_req_t [`HBIC_PORTS-1:0]    aw_req_i,
	input  wire hbic_bus_pkg::addr_req_t [`HBIC_PORTS-1:0]    ar_req_i,
	input  wire hbic_bus_pkg::w_beat_t   [`HBIC_PORTS-1:0]    w_beat_i,
	input  wire                          [`HBIC_PORTS-1:0]    w_valid_i,
	input  wire                                               arw_ready_i,
	input  wire                                               mw_ready_i,
	output logic                                              grant_ready_o,
	output hbic_bus_pkg::arw_req_t                            arw_o,
	output logic                                              arw_valid_o,
	output logic                         [`HBIC_PORTS-1:0]    w_ready_o,
	output hbic_bus_pkg::w_beat_t                             mw_beat_o,
	output logic                                              mw_valid_o
);

	hbic_port_pkg::merge_state_e state_q;
	hbic_port_pkg::merge_state_e state_d;
	hbic_port_pkg::port_idx_t    sel_port; // master behind the grant
	hbic_port_pkg::port_idx_t    owner_q;  // master holding write data
	hbic_bus_pkg::addr_req_t     sel_req;
	logic                        sel_read;
	logic                        grant_hs;
	logic                        w_done;

	assign sel_port = grant_i[$bits(grant_i)-1:1];
	assign sel_read = grant_i[0];
	assign sel_req  = sel_read ? ar_req_i[sel_port] : aw_req_i[sel_port];

	// output slot free or draining, and no write burst still open
	assign grant_ready_o = (state_q == hbic_port_pkg::IDLE) && (!arw_valid_o || arw_ready_i);
	assign grant_hs      = grant_valid_i && grant_ready_o;

	// combined request register, one cycle after the grant handshake
	always_ff @(posedge sys_clk_i) begin
		if (grant_hs) begin
			arw_o.id    <= hbic_bus_pkg::id_t'(sel_port);
			arw_o.addr  <= sel_req.addr;
			arw_o.len   <= sel_req.len;
			arw_o.write <= !sel_read;
		end
	end

	always_ff @(posedge sys_clk_i) begin
		if (rst_i) begin
			arw_valid_o <= 1'b0;
		end else if (grant_hs) begin
			arw_valid_o <= 1'b1;
		end else if (arw_ready_i) begin
			arw_valid_o <= 1'b0;
		end
	end

	// write data steering, owner passes straight through to memory
	assign mw_beat_o  = w_beat_i[owner_q];
	assign mw_valid_o = (state_q == hbic_port_pkg::WDATA) && w_valid_i[owner_q];
	assign w_done     = mw_valid_o && mw_ready_i && mw_beat_o.last;

	always_comb begin
		for (int p = 0; p < `HBIC_PORTS; p++) begin
			w_ready_o[p] = (state_q == hbic_port_pkg::WDATA) &&
				(owner_q == hbic_port_pkg::port_idx_t'(p)) && mw_ready_i;
		end
	end

	// reads leave the state alone so many can be outstanding
	always_comb begin
		state_d = state_q;
		case (state_q)
			hbic_port_pkg::IDLE: begin
				if (grant_hs && !sel_read) begin
					state_d = hbic_port_pkg::WDATA;
				end
			end
			hbic_port_pkg::WDATA: begin
				if (w_done) begin
					state_d = hbic_port_pkg::IDLE; // last beat gone
				end
			end
			default: state_d = hbic_port_pkg::IDLE;
		endcase
	end

	always_ff @(posedge sys_clk_i) begin
		if (rst_i) begin
			state_q <= hbic_port_pkg::IDLE;
			owner_q <= '0;
		end else begin
			state_q <= state_d;
			if (grant_hs && !sel_read) begin
				owner_q <= sel_port;
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/read_return_router.sv
`timescale 1ns/10ps
`default_nettype none

`include "hbic_cfg.svh"

module read_return_router (
	input  wire hbic_bus_pkg::r_beat_t                       mr_beat_i,
	input  wire                                              mr_valid_i,
	input  wire                        [`HBIC_PORTS-1:0]     r_ready_i,
	output logic                                             mr_ready_o,
	output hbic_bus_pkg::r_beat_t      [`HBIC_PORTS-1:0]     r_beat_o,
	output logic                       [`HBIC_PORTS-1:0]     r_valid_o
);

	hbic_port_pkg::port_idx_t dst; // owning master from the id

	// id carries the master index in its low bits
	assign dst = hbic_port_pkg::port_idx_t'(mr_beat_i.id);

	// payload to everyone, valid only to the owner
	always_comb begin
		for (int p = 0; p < `HBIC_PORTS; p++) begin
			r_beat_o[p]  = mr_beat_i;
			r_valid_o[p] = mr_valid_i && (dst == hbic_port_pkg::port_idx_t'(p));
		end
	end

	// a stalled owner holds the whole read stream
	assign mr_ready_o = r_ready_i[dst];

endmodule

`default_nettype wire

//--- rtl/hbram_interconnect.sv
`timescale 1ns/10ps
`default_nettype none

`include "hbic_cfg.svh"

module hbram_interconnect (
	input  wire                                               sys_clk_i,
	input  wire                                               rst_i,

	// master side
	input  wire hbic_bus_pkg::addr_req_t [`HBIC_PORTS-1:0]    aw_req_i,
	input  wire                          [`HBIC_PORTS-1:0]    aw_valid_i,
	output logic                         [`HBIC_PORTS-1:0]    aw_ready_o,
	input  wire hbic_bus_pkg::addr_req_t [`HBIC_PORTS-1:0]    ar_req_i,
	input  wire                          [`HBIC_PORTS-1:0]    ar_valid_i,
	output logic                         [`HBIC_PORTS-1:0]    ar_ready_o,
	input  wire hbic_bus_pkg::w_beat_t   [`HBIC_PORTS-1:0]    w_beat_i,
	input  wire                          [`HBIC_PORTS-1:0]    w_valid_i,
	output logic                         [`HBIC_PORTS-1:0]    w_ready_o,
	output hbic_bus_pkg::r_beat_t        [`HBIC_PORTS-1:0]    r_beat_o,
	output logic                         [`HBIC_PORTS-1:0]    r_valid_o,
	input  wire                          [`HBIC_PORTS-1:0]    r_ready_i,

	// memory controller side
	output hbic_bus_pkg::arw_req_t                            arw_o,
	output logic                                              arw_valid_o,
	input  wire                                               arw_ready_i,
	output hbic_bus_pkg::w_beat_t                             mw_beat_o,
	output logic                                              mw_valid_o,
	input  wire                                               mw_ready_i,
	input  wire hbic_bus_pkg::r_beat_t                        mr_beat_i,
	input  wire                                               mr_valid_i,
	output logic                                              mr_ready_o
);

	hbic_port_pkg::src_idx_t grant;
	logic                    grant_valid;
	logic                    grant_ready;

	request_arbiter request_arbiter_inst (
		.sys_clk_i     (sys_clk_i),
		.rst_i         (rst_i),
		.aw_valid_i    (aw_valid_i),
		.ar_valid_i    (ar_valid_i),
		.grant_ready_i (grant_ready),
		.grant_o       (grant),
		.grant_valid_o (grant_valid),
		.aw_ready_o    (aw_ready_o),
		.ar_ready_o    (ar_ready_o)
	);

	arw_merger arw_merger_inst (
		.sys_clk_i     (sys_clk_i),
		.rst_i         (rst_i),
		.grant_i       (grant),
		.grant_valid_i (grant_valid),
		.aw_req_i      (aw_req_i),
		.ar_req_i      (ar_req_i),
		.w_beat_i      (w_beat_i),
		.w_valid_i     (w_valid_i),
		.arw_ready_i   (arw_ready_i),
		.mw_ready_i    (mw_ready_i),
		.grant_ready_o (grant_ready),
		.arw_o         (arw_o),
		.arw_valid_o   (arw_valid_o),
		.w_ready_o     (w_ready_o),
		.mw_beat_o     (mw_beat_o),
		.mw_valid_o    (mw_valid_o)
	);

	read_return_router read_return_router_inst (
		.mr_beat_i  (mr_beat_i),
		.mr_valid_i (mr_valid_i),
		.r_ready_i  (r_ready_i),
		.mr_ready_o (mr_ready_o),
		.r_beat_o   (r_beat_o),
		.r_valid_o  (r_valid_o)
	);

endmodule

`default_nettype wire

//--- bench/tb_mem_responder.sv
`timescale 1ns/10ps
`default_nettype none

`include "hbic_cfg.svh"

module tb_mem_responder (
	input  wire                          sys_clk_i,
	input  wire                    [2:0] stall_i, // arw, mw, mr
	input  wire hbic_bus_pkg::arw_req_t  arw_i,
	input  wire                          arw_valid_i,
	output logic                         arw_ready_o,
	input  wire hbic_bus_pkg::w_beat_t   mw_beat_i,
	input  wire                          mw_valid_i,
	output logic                         mw_ready_o,
	output hbic_bus_pkg::r_beat_t        mr_beat_o,
	output logic                         mr_valid_o,
	input  wire                          mr_ready_i
);

	hbic_bus_pkg::arw_req_t wr_q [$]; // accepted writes waiting for data
	hbic_bus_pkg::arw_req_t rd_q [$]; // accepted reads, answered in order
	hbic_bus_pkg::data_t    mem [hbic_bus_pkg::addr_t];
	hbic_bus_pkg::r_beat_t  beat_n;
	hbic_bus_pkg::addr_t    a;
	logic                   arw_rdy_n = 1'b0;
	logic                   mw_rdy_n = 1'b0;
	logic                   mr_val_n = 1'b0;
	int                     wr_beat = 0;
	int                     rd_beat = 0;

	// contents of a location never written
	function automatic hbic_bus_pkg::data_t fill_word(input hbic_bus_pkg::addr_t fa);
		return {fa, ~fa, fa ^ 32'h5a5a_c3c3, fa + 32'h1234_5678};
	endfunction

	initial begin
		arw_ready_o = 1'b0;
		mw_ready_o  = 1'b0;
		mr_valid_o  = 1'b0;
		mr_beat_o   = '0;
		beat_n      = '0;
		forever begin
			@(negedge sys_clk_i);
			arw_ready_o = arw_rdy_n;
			mw_ready_o  = mw_rdy_n;
			mr_valid_o  = mr_val_n;
			mr_beat_o   = beat_n;
			#1; // inputs settled, these transfers happen at the next rising edge
			if (arw_valid_i && arw_ready_o) begin
				if (arw_i.write) wr_q.push_back(arw_i);
				else rd_q.push_back(arw_i);
			end
			if (mw_valid_i && mw_ready_o) begin
				a = wr_q[0].addr + 16 * wr_beat;
				if (!mem.exists(a)) mem[a] = fill_word(a);
				for (int i = 0; i < `HBIC_STRB_W; i++) begin
					if (mw_beat_i.strb[i]) mem[a][8*i +: 8] = mw_beat_i.data[8*i +: 8];
				end
				wr_beat++;
				if (wr_beat > wr_q[0].len) begin
					void'(wr_q.pop_front());
					wr_beat = 0;
				end
			end
			if (mr_valid_o && mr_ready_i) begin
				rd_beat++;
				if (mr_beat_o.last) begin
					void'(rd_q.pop_front());
					rd_beat = 0;
				end
			end
			arw_rdy_n = !stall_i[0];
			mw_rdy_n  = (wr_q.size() != 0) && !stall_i[1];
			if (mr_valid_o && !mr_ready_i) begin
				mr_val_n = 1'b1; // held until taken
			end else if (rd_q.size() != 0 && !stall_i[2]) begin
				a           = rd_q[0].addr + 16 * rd_beat;
				beat_n.id   = rd_q[0].id;
				beat_n.data = mem.exists(a) ? mem[a] : fill_word(a);
				beat_n.last = (rd_beat == rd_q[0].len);
				mr_val_n    = 1'b1;
			end else begin
				mr_val_n = 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

//--- bench/tb_hbram_interconnect.sv
`timescale 1ns/10ps
`default_nettype none

`include "hbic_cfg.svh"

module tb_hbram_interconnect;

	localparam int NP        = `HBIC_PORTS;
	localparam int RR_ROUNDS = 3;

	logic sys_clk;
	logic rst;
	hbic_bus_pkg::addr_req_t [NP-1:0] aw_req;
	hbic_bus_pkg::addr_req_t [NP-1:0] ar_req;
	hbic_bus_pkg::w_beat_t   [NP-1:0] w_beat;
	hbic_bus_pkg::r_beat_t   [NP-1:0] r_beat;
	logic [NP-1:0] aw_valid;
	logic [NP-1:0] aw_ready;
	logic [NP-1:0] ar_valid;
	logic [NP-1:0] ar_ready;
	logic [NP-1:0] w_valid;
	logic [NP-1:0] w_ready;
	logic [NP-1:0] r_valid;
	logic [NP-1:0] r_ready;
	hbic_bus_pkg::arw_req_t arw;
	hbic_bus_pkg::w_beat_t  mw_beat;
	hbic_bus_pkg::r_beat_t  mr_beat;
	logic arw_valid;
	logic arw_ready;
	logic mw_valid;
	logic mw_ready;
	logic mr_valid;
	logic mr_ready;
	logic [2:0]  stall;
	logic        back_pressure = 1'b0;
	logic        rr_check = 1'b0;
	logic [15:0] lfsr_q = 16'd52;
	int error_cnt = 0;
	int arw_cnt = 0;
	int w_cnt = 0;
	int r_cnt = 0;
	int beats_issued = 0;
	int cycle_cnt = 0;

	hbic_bus_pkg::addr_req_t exp_aw_q [NP][$];
	hbic_bus_pkg::addr_req_t exp_ar_q [NP][$];
	hbic_bus_pkg::r_beat_t   exp_r_q [NP][$];
	hbic_bus_pkg::w_beat_t   exp_w_q [$]; // writes are serialized into one global order
	hbic_port_pkg::src_idx_t exp_src_q [$];
	hbic_bus_pkg::data_t     ref_mem [hbic_bus_pkg::addr_t];

	hbram_interconnect hbram_interconnect_inst (
		.sys_clk_i   (sys_clk),
		.rst_i       (rst),
		.aw_req_i    (aw_req),
		.aw_valid_i  (aw_valid),
		.aw_ready_o  (aw_ready),
		.ar_req_i    (ar_req),
		.ar_valid_i  (ar_valid),
		.ar_ready_o  (ar_ready),
		.w_beat_i    (w_beat),
		.w_valid_i   (w_valid),
		.w_ready_o   (w_ready),
		.r_beat_o    (r_beat),
		.r_valid_o   (r_valid),
		.r_ready_i   (r_ready),
		.arw_o       (arw),
		.arw_valid_o (arw_valid),
		.arw_ready_i (arw_ready),
		.mw_beat_o   (mw_beat),
		.mw_valid_o  (mw_valid),
		.mw_ready_i  (mw_ready),
		.mr_beat_i   (mr_beat),
		.mr_valid_i  (mr_valid),
		.mr_ready_o  (mr_ready)
	);

	tb_mem_responder tb_mem_responder_inst (
		.sys_clk_i   (sys_clk),
		.stall_i     (stall),
		.arw_i       (arw),
		.arw_valid_i (arw_valid),
		.arw_ready_o (arw_ready),
		.mw_beat_i   (mw_beat),
		.mw_valid_i  (mw_valid),
		.mw_ready_o  (mw_ready),
		.mr_beat_o   (mr_beat),
		.mr_valid_o  (mr_valid),
		.mr_ready_i  (mr_ready)
	);

	// fibonacci lfsr on taps 16 14 13 11 stepped once per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
			v      = {v[30:0], lfsr_q[0]};
		end
		return v;
	endfunction

	function automatic hbic_bus_pkg::data_t mem_word(input hbic_bus_pkg::addr_t a);
		if (ref_mem.exists(a)) return ref_mem[a];
		return {a, ~a, a ^ 32'h5a5a_c3c3, a + 32'h1234_5678}; // never written
	endfunction

	function automatic int pending();
		int n;
		n = exp_w_q.size() + exp_src_q.size();
		for (int p = 0; p < NP; p++) begin
			n += exp_aw_q[p].size() + exp_ar_q[p].size() + exp_r_q[p].size();
		end
		return n;
	endfunction

	task automatic flag_error(input string msg);
		error_cnt++;
		$display("ERROR @%0t: %s", $time, msg);
	endtask

	task automatic write_burst(input int p, input hbic_bus_pkg::addr_t addr,
		input hbic_bus_pkg::len_t len);
		hbic_bus_pkg::w_beat_t beats [4];
		hbic_bus_pkg::addr_t   a;
		for (int b = 0; b <= len; b++) begin
			beats[b].data = {rand_bits(32), rand_bits(32), rand_bits(32), rand_bits(32)};
			beats[b].strb = hbic_bus_pkg::strb_t'(rand_bits(16));
			beats[b].last = (b == len);
		end
		@(negedge sys_clk);
		aw_req[p]   = '{addr: addr, len: len};
		aw_valid[p] = 1'b1;
		#1;
		while (!aw_ready[p]) begin
			@(negedge sys_clk);
			#1;
		end
		exp_aw_q[p].push_back(aw_req[p]); // taken at the coming edge
		beats_issued += len + 1;
		for (int b = 0; b <= len; b++) begin
			exp_w_q.push_back(beats[b]);
			a = addr + 16 * b;
			ref_mem[a] = mem_word(a);
			for (int i = 0; i < `HBIC_STRB_W; i++) begin
				if (beats[b].strb[i]) ref_mem[a][8*i +: 8] = beats[b].data[8*i +: 8];
			end
		end
		@(negedge sys_clk);
		aw_valid[p] = 1'b0;
		for (int b = 0; b <= len; b++) begin
			w_beat[p]  = beats[b];
			w_valid[p] = 1'b1;
			#1;
			while (!w_ready[p]) begin
				@(negedge sys_clk);
				#1;
			end
			@(negedge sys_clk);
		end
		w_valid[p] = 1'b0;
	endtask

	task automatic read_burst(input int p, input hbic_bus_pkg::addr_t addr,
		input hbic_bus_pkg::len_t len);
		@(negedge sys_clk);
		ar_req[p]   = '{addr: addr, len: len};
		ar_valid[p] = 1'b1;
		#1;
		while (!ar_ready[p]) begin
			@(negedge sys_clk);
			#1;
		end
		exp_ar_q[p].push_back(ar_req[p]);
		for (int b = 0; b <= len; b++) begin
			exp_r_q[p].push_back('{id: hbic_bus_pkg::id_t'(p), data: mem_word(addr + 16 * b),
				last: (b == len)});
		end
		beats_issued += len + 1;
		@(negedge sys_clk);
		ar_valid[p] = 1'b0; // returns before the data so reads overlap
	endtask

	function automatic hbic_bus_pkg::addr_t far_addr(input int p);
		return 32'h8000_0000 + (p << 12) + (rand_bits(6) << 4);
	endfunction

	// write and read raised on the same edge, raised again once both are through
	task automatic pair_traffic(input int p);
		hbic_bus_pkg::len_t wl;
		hbic_bus_pkg::len_t rl;
		for (int round = 0; round < RR_ROUNDS; round++) begin
			wl = hbic_bus_pkg::len_t'(rand_bits(2));
			rl = hbic_bus_pkg::len_t'(rand_bits(2));
			fork
				write_burst(p, ((p + 1) << 16) + (8 + round) * 64, wl);
				read_burst(p, far_addr(p), rl);
			join
		end
	endtask

	task automatic mixed_traffic(input int p);
		hbic_bus_pkg::len_t l;
		for (int k = 0; k < 6; k++) begin
			l = hbic_bus_pkg::len_t'(rand_bits(2));
			write_burst(p, ((p + 1) << 16) + k * 64, l);
			read_burst(p, ((p + 1) << 16) + k * 64, l); // read back own data
			read_burst(p, far_addr(p), hbic_bus_pkg::len_t'(rand_bits(2)));
		end
	endtask

	initial begin
		sys_clk = 1'b0;
		forever #4 sys_clk = ~sys_clk;
	end

	initial begin
		forever begin
			@(negedge sys_clk);
			stall   = back_pressure ? 3'(rand_bits(3)) : 3'b000;
			r_ready = back_pressure ? NP'(rand_bits(NP)) : '1;
		end
	end

	initial begin : transfer_monitor
		int p;
		forever begin
			@(negedge sys_clk);
			#2;
			if (!rst && arw_valid && arw_ready) begin
				arw_cnt++;
				p = arw.id[1:0];
				assert (arw.id < NP) else flag_error($sformatf("request id %0d out of range", arw.id));
				if (rr_check) begin
					assert (exp_src_q.size() > 0 && exp_src_q[0] == {arw.id[1:0], !arw.write})
						else flag_error($sformatf("round robin order broken at id %0d write %0b",
							arw.id, arw.write));
					if (exp_src_q.size() > 0) void'(exp_src_q.pop_front());
				end
				if (arw.write) begin
					assert (exp_aw_q[p].size() > 0 && exp_aw_q[p][0] == {arw.addr, arw.len})
						else flag_error($sformatf("write request id %0d addr %h len %0d not expected",
							arw.id, arw.addr, arw.len));
					if (exp_aw_q[p].size() > 0) void'(exp_aw_q[p].pop_front());
				end else begin
					assert (exp_ar_q[p].size() > 0 && exp_ar_q[p][0] == {arw.addr, arw.len})
						else flag_error($sformatf("read request id %0d addr %h len %0d not expected",
							arw.id, arw.addr, arw.len));
					if (exp_ar_q[p].size() > 0) void'(exp_ar_q[p].pop_front());
				end
			end
			if (!rst && mw_valid && mw_ready) begin
				w_cnt++;
				assert (exp_w_q.size() > 0 && mw_beat == exp_w_q[0])
					else flag_error($sformatf("write beat %h strb %h last %0b not expected",
						mw_beat.data, mw_beat.strb, mw_beat.last));
				if (exp_w_q.size() > 0) void'(exp_w_q.pop_front());
			end
			assert ($countones(w_ready) <= 1)
				else flag_error("write ready raised toward several masters");
			assert ($countones(r_valid) <= 1)
				else flag_error("read beat valid toward several masters");
			for (p = 0; p < NP; p++) begin
				if (!rst && r_valid[p] && r_ready[p]) begin
					r_cnt++;
					assert (exp_r_q[p].size() > 0 && r_beat[p] == exp_r_q[p][0])
						else flag_error($sformatf("master %0d got read beat id %0d data %h last %0b",
							p, r_beat[p].id, r_beat[p].data, r_beat[p].last));
					if (exp_r_q[p].size() > 0) void'(exp_r_q[p].pop_front());
				end
			end
		end
	end

	// limit grows with the beats actually issued
	initial begin
		while (cycle_cnt <= 40 * (beats_issued + 16)) begin
			@(posedge sys_clk);
			cycle_cnt++;
		end
		$display("timeout: transfers still open after %0d cycles", cycle_cnt);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	initial begin
		rst      = 1'b1;
		aw_req   = '0;
		ar_req   = '0;
		w_beat   = '0;
		aw_valid = '0;
		ar_valid = '0;
		w_valid  = '0;
		r_ready  = '1;
		stall    = 3'b000;
		repeat (3) @(posedge sys_clk);
		@(negedge sys_clk);
		rst = 1'b0;
		repeat (4) begin
			@(negedge sys_clk);
			#2;
			assert (!arw_valid && !mw_valid && r_valid == '0 && aw_ready == '0 &&
				ar_ready == '0 && w_ready == '0)
				else flag_error("outputs not idle after reset");
		end
		rr_check = 1'b1;
		for (int round = 0; round < RR_ROUNDS; round++) begin
			for (int s = 0; s < 2 * NP; s++) begin
				exp_src_q.push_back(hbic_port_pkg::src_idx_t'(s)); // pointer wraps to 0
			end
		end
		fork
			pair_traffic(0);
			pair_traffic(1);
			pair_traffic(2);
			pair_traffic(3);
		join
		while (pending() != 0) @(negedge sys_clk);
		rr_check      = 1'b0;
		back_pressure = 1'b1;
		fork
			mixed_traffic(0);
			mixed_traffic(1);
			mixed_traffic(2);
			mixed_traffic(3);
		join
		while (pending() != 0) @(negedge sys_clk);
		repeat (4) @(negedge sys_clk);
		$display("requests %0d, write beats %0d, read beats %0d, errors %0d",
			arw_cnt, w_cnt, r_cnt, error_cnt);
		if (error_cnt == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- files.f
+incdir+rtl
rtl/hbic_bus_pkg.sv
rtl/hbic_port_pkg.sv
rtl/request_arbiter.sv
rtl/arw_merger.sv
rtl/read_return_router.sv
rtl/hbram_interconnect.sv
bench/tb_mem_responder.sv
bench/tb_hbram_interconnect.sv
